// File: rtl/spi_proto_pkg.sv
/*
 * SPI command codes, received byte type and byte counter type
 * keyboard prefix bytes seen in the 0x05 command payload
 */

`default_nettype none

package spi_proto_pkg;

	// one byte as assembled from SPI_MOSI, MSB first on the wire
	typedef logic [7:0] spi_byte_t;

	// first byte of every transfer selects the command
	typedef enum logic [7:0] {
		// buttons, switches and video mode bits
		cmd_buttons      = 8'h01,
		// raw ps/2 keyboard bytes
		cmd_key          = 8'h05,
		// 8-bit status, zero-extended
		cmd_status_short = 8'h15,
		// 64-bit status, 8 bytes LSB first
		cmd_status_long  = 8'h1e,
		// core variant
		cmd_core_mod     = 8'h21,
		// digital joysticks 0..4 occupy 0x60..0x64
		cmd_joy_base     = 8'h60,
		cmd_joy_last     = 8'h64
	} cmd_e;

	// saturating count of bytes in the current transfer
	// byte 0 is the command itself
	typedef logic [7:0] byte_cnt_t;

	// extended scan code prefix
	localparam spi_byte_t KEY_EXT_PREFIX = 8'he0;

	// break (key release) prefix
	localparam spi_byte_t KEY_BREAK_PREFIX = 8'hf0;

endpackage

`default_nettype wire

// File: rtl/core_io_pkg.sv
/*
 * core-facing output types: board control, joysticks, status, core variant
 * key event struct and ps/2 frame step constants
 */

`default_nettype none

package core_io_pkg;

	// bits 6..0 of the 0x01 payload, buttons in the low bits
	typedef struct packed {
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} board_ctrl_t;

	// one digital joystick, byte 0 of the payload in bits 7..0
	typedef logic [31:0] joystick_t;

	// joysticks addressed by commands 0x60..0x64
	localparam int NUM_JOYSTICKS = 5;

	typedef logic [63:0] status_t;

	typedef logic [6:0] core_mod_t;

	// decoded key event, valid with key_strobe
	typedef struct packed {
		// 1 = make, 0 = break
		logic       pressed;
		// code followed an 0xe0 prefix
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	// start, 8 data, parity and stop take steps 0..10, step 11 returns to idle
	localparam int PS2_FRAME_STEPS = 11;

	// step counter of the frame transmitter, 0 means idle
	typedef logic [3:0] ps2_step_t;

endpackage

`default_nettype wire

// File: rtl/spi_byte_rx.sv
/*
 * SPI_CLK-domain receiver with bit counter, shift register and byte latch
 * hands bytes to clk_sys through a toggle and a transfer-end level
 */

`timescale 1ns/10ps
`default_nettype none

module spi_byte_rx (
	input  logic                      SPI_CLK,
	input  logic                      SPI_SS_IO,
	input  logic                      SPI_MOSI,
	output spi_proto_pkg::spi_byte_t  rx_byte,
	// power-up level matches the clk_sys synchronizer
	output logic                      rx_toggle = 1'b0,
	output logic                      xfer_end
);

	// position of the next incoming bit with 7 for the last bit of a byte
	logic [2:0] bit_cnt;
	// first seven bits of the byte under assembly
	logic [6:0] sbuf;

	// counter, shift register and transfer-end flag
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= 3'd0;
			sbuf     <= 7'd0;
			xfer_end <= 1'b1;
		end else begin
			// first clock edge of a transfer drops the end flag
			xfer_end <= 1'b0;
			bit_cnt  <= bit_cnt + 3'd1;
			if (bit_cnt != 3'd7) begin
				sbuf <= {sbuf[5:0], SPI_MOSI};
			end
		end
	end

	// byte latch and toggle strobe
	always_ff @(posedge SPI_CLK) begin
		// 8th edge takes the last bit straight from the pin
		if (bit_cnt == 3'd7) begin
			rx_byte   <= {sbuf, SPI_MOSI};
			// every change of rx_toggle marks a new rx_byte
			rx_toggle <= ~rx_toggle;
		end
	end

endmodule

`default_nettype wire

// File: rtl/io_cmd_decoder.sv
/*
 * clk_sys command decoder: toggle synchronizer, byte counter, dispatch
 * to board control, joystick, status and core variant registers and keyboard
 */

`timescale 1ns/10ps
`default_nettype none

module io_cmd_decoder (
	input  logic                                          clk_sys,
	input  spi_proto_pkg::spi_byte_t                      rx_byte,
	input  logic                                          rx_toggle,
	input  logic                                          xfer_end,
	output core_io_pkg::board_ctrl_t                      board_ctrl = '0,
	output core_io_pkg::joystick_t [core_io_pkg::NUM_JOYSTICKS-1:0] joysticks = '0,
	output core_io_pkg::status_t                          status = '0,
	output core_io_pkg::core_mod_t                        core_mod = '0,
	output core_io_pkg::key_event_t                       key = '0,
	output logic                                          key_strobe = 1'b0,
	output logic                                          push = 1'b0,
	output spi_proto_pkg::spi_byte_t                      push_byte = '0
);

	// toggle synchronizer, bits 1 and 2 compared for the edge
	logic [2:0] tog_sync = 3'b000;
	// transfer-end synchronizer, starts out between transfers
	logic [1:0] end_sync = 2'b11;

	spi_proto_pkg::spi_byte_t cmd = '0;
	spi_proto_pkg::byte_cnt_t byte_cnt = '0;

	// keyboard prefix state within one 0x05 transfer
	logic key_ext_r = 1'b0;
	logic key_press_r = 1'b1;

	logic                     byte_take;
	logic                     first_byte;
	logic [2:0]               lane;
	spi_proto_pkg::spi_byte_t joy_off;
	logic [2:0]               joy_idx;

	assign byte_take  = tog_sync[1] ^ tog_sync[2];
	assign first_byte = (byte_cnt == 8'd1);
	// payload byte n lands in byte lane n-1
	assign lane       = byte_cnt[2:0] - 3'd1;
	assign joy_off    = cmd - spi_proto_pkg::cmd_joy_base;
	assign joy_idx    = joy_off[2:0];

	always_ff @(posedge clk_sys) begin
		tog_sync <= {tog_sync[1:0], rx_toggle};
		end_sync <= {end_sync[0], xfer_end};

		// single-cycle strobes
		key_strobe <= 1'b0;
		push       <= 1'b0;

		if (end_sync[1]) begin
			byte_cnt <= '0;
		end else if (byte_take) begin
			// saturate instead of wrapping on long transfers
			if (byte_cnt != 8'hff) begin
				byte_cnt <= byte_cnt + 8'd1;
			end

			if (byte_cnt == 8'd0) begin
				cmd <= rx_byte;
			end else begin
				case (cmd)
					spi_proto_pkg::cmd_buttons: begin
						board_ctrl <= core_io_pkg::board_ctrl_t'(rx_byte[6:0]);
					end
					spi_proto_pkg::cmd_status_short: begin
						status <= {56'd0, rx_byte};
					end
					spi_proto_pkg::cmd_status_long: begin
						// bytes past the 8th are dropped
						if (byte_cnt < 8'd9) begin
							status[8*lane +: 8] <= rx_byte;
						end
					end
					spi_proto_pkg::cmd_core_mod: begin
						core_mod <= rx_byte[6:0];
					end
					spi_proto_pkg::cmd_key: begin
						// raw byte always goes out on ps/2, prefixes too
						push      <= 1'b1;
						push_byte <= rx_byte;
						// new transfer, new key
						if (first_byte) begin
							key_ext_r   <= 1'b0;
							key_press_r <= 1'b1;
						end
						if (rx_byte == spi_proto_pkg::KEY_EXT_PREFIX) begin
							key_ext_r <= 1'b1;
						end else if (rx_byte == spi_proto_pkg::KEY_BREAK_PREFIX) begin
							key_press_r <= 1'b0;
						end else begin
							// on byte 1 the prefix flags are stale, use defaults
							key.pressed  <= key_press_r | first_byte;
							key.extended <= key_ext_r & ~first_byte;
							key.code     <= rx_byte;
							key_strobe   <= 1'b1;
						end
					end
					default: begin
						// joysticks 0x60..0x64, four bytes each
						if (cmd >= spi_proto_pkg::cmd_joy_base &&
							cmd <= spi_proto_pkg::cmd_joy_last &&
							byte_cnt < 8'd5) begin
							joysticks[joy_idx][8*lane[1:0] +: 8] <= rx_byte;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/ps2_clk_div.sv
/*
 * ps/2 clock divider, level output and one-cycle tick on each rise
 */

`timescale 1ns/10ps
`default_nettype none

module ps2_clk_div #(
	parameter int PS2_DIV = 100
) (
	input  logic clk_sys,
	output logic ps2_clk = 1'b0,
	output logic ps2_tick = 1'b0
);

	localparam int CNT_W = $clog2(PS2_DIV + 1);

	// counts 0..PS2_DIV, so half a ps/2 period is PS2_DIV+1 cycles
	logic [CNT_W-1:0] cnt = '0;

	always_ff @(posedge clk_sys) begin
		ps2_tick <= 1'b0;
		if (cnt == CNT_W'(PS2_DIV)) begin
			cnt     <= '0;
			ps2_clk <= ~ps2_clk;
			// tick only when the level goes low to high
			ps2_tick <= ~ps2_clk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/ps2_byte_fifo.sv
/*
 * circular byte FIFO between keyboard decode and the ps/2 transmitter
 */

`timescale 1ns/10ps
`default_nettype none

module ps2_byte_fifo #(
	parameter int PS2_FIFO_BITS = 3
) (
	input  logic                     clk_sys,
	input  logic                     push,
	input  spi_proto_pkg::spi_byte_t push_byte,
	input  logic                     pop,
	output logic                     not_empty,
	output spi_proto_pkg::spi_byte_t head
);

	localparam int DEPTH = 2 ** PS2_FIFO_BITS;

	spi_proto_pkg::spi_byte_t mem [DEPTH];

	// pointers wrap freely, overflow overwrites unsent bytes
	logic [PS2_FIFO_BITS-1:0] wptr = '0;
	logic [PS2_FIFO_BITS-1:0] rptr = '0;

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wptr] <= push_byte;
			wptr      <= wptr + 1'b1;
		end
		if (pop) begin
			rptr <= rptr + 1'b1;
		end
	end

	// oldest byte always visible to the transmitter
	assign head      = mem[rptr];
	assign not_empty = (wptr != rptr);

endmodule

`default_nettype wire

// File: rtl/ps2_tx_fsm.sv
/*
 * ps/2 frame transmitter: start, 8 data bits LSB first, odd parity, stop
 * advances one step per ps/2 clock rise, gates the clock while idle
 */

`timescale 1ns/10ps
`default_nettype none

module ps2_tx_fsm (
	input  logic                     clk_sys,
	input  logic                     ps2_tick,
	input  logic                     ps2_clk,
	input  logic                     not_empty,
	input  spi_proto_pkg::spi_byte_t head,
	output logic                     pop = 1'b0,
	output logic                     ps2_kbd_clk,
	output logic                     ps2_kbd_data = 1'b1
);

	localparam core_io_pkg::ps2_step_t LAST_STEP =
		core_io_pkg::ps2_step_t'(core_io_pkg::PS2_FRAME_STEPS);

	// 0 idle, 1..8 data, 9 parity, 10 stop, 11 back to idle
	core_io_pkg::ps2_step_t step = '0;

	// data bits still to send, shifted out from bit 0
	spi_proto_pkg::spi_byte_t shreg = '0;
	// running odd parity
	logic parity = 1'b1;

	always_ff @(posedge clk_sys) begin
		pop <= 1'b0;
		if (ps2_tick) begin
			if (step == '0) begin
				if (not_empty) begin
					shreg  <= head;
					pop    <= 1'b1;
					parity <= 1'b1;
					step   <= 4'd1;
					// start bit
					ps2_kbd_data <= 1'b0;
				end
			end else begin
				if (step <= 4'd8) begin
					ps2_kbd_data <= shreg[0];
					shreg        <= {1'b0, shreg[7:1]};
					if (shreg[0]) begin
						parity <= ~parity;
					end
				end else if (step == 4'd9) begin
					ps2_kbd_data <= parity;
				end else if (step == 4'd10) begin
					// stop bit, line then rests high
					ps2_kbd_data <= 1'b1;
				end

				if (step == LAST_STEP) begin
					step <= '0;
				end else begin
					step <= step + 4'd1;
				end
			end
		end
	end

	// clock only runs while a frame is in progress
	assign ps2_kbd_clk = ps2_clk | (step == '0);

endmodule

`default_nettype wire

// File: rtl/user_io_top.sv
/*
 * SPI slave receive path top: byte receiver, command decoder,
 * keyboard FIFO, ps/2 clock divider and frame transmitter
 */

`timescale 1ns/10ps
`default_nettype none

module user_io_top #(
	parameter int PS2_DIV       = 100,
	parameter int PS2_FIFO_BITS = 3
) (
	input  logic                                          clk_sys,
	input  logic                                          SPI_SS_IO,
	input  logic                                          SPI_CLK,
	input  logic                                          SPI_MOSI,
	output core_io_pkg::board_ctrl_t                      board_ctrl,
	output core_io_pkg::joystick_t [core_io_pkg::NUM_JOYSTICKS-1:0] joysticks,
	output core_io_pkg::status_t                          status,
	output core_io_pkg::core_mod_t                        core_mod,
	output core_io_pkg::key_event_t                       key,
	output logic                                          key_strobe,
	output logic                                          ps2_kbd_clk,
	output logic                                          ps2_kbd_data
);

	// SPI_CLK domain to clk_sys
	spi_proto_pkg::spi_byte_t rx_byte;
	logic                     rx_toggle;
	logic                     xfer_end;

	// keyboard bytes into the FIFO
	logic                     push;
	spi_proto_pkg::spi_byte_t push_byte;

	// FIFO to transmitter
	logic                     pop;
	logic                     not_empty;
	spi_proto_pkg::spi_byte_t head;

	logic                     ps2_clk;
	logic                     ps2_tick;

	spi_byte_rx i_rx (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_MOSI  (SPI_MOSI),
		.rx_byte   (rx_byte),
		.rx_toggle (rx_toggle),
		.xfer_end  (xfer_end)
	);

	io_cmd_decoder i_dec (
		.clk_sys    (clk_sys),
		.rx_byte    (rx_byte),
		.rx_toggle  (rx_toggle),
		.xfer_end   (xfer_end),
		.board_ctrl (board_ctrl),
		.joysticks  (joysticks),
		.status     (status),
		.core_mod   (core_mod),
		.key        (key),
		.key_strobe (key_strobe),
		.push       (push),
		.push_byte  (push_byte)
	);

	ps2_clk_div #(
		.PS2_DIV (PS2_DIV)
	) i_div (
		.clk_sys  (clk_sys),
		.ps2_clk  (ps2_clk),
		.ps2_tick (ps2_tick)
	);

	ps2_byte_fifo #(
		.PS2_FIFO_BITS (PS2_FIFO_BITS)
	) i_fifo (
		.clk_sys   (clk_sys),
		.push      (push),
		.push_byte (push_byte),
		.pop       (pop),
		.not_empty (not_empty),
		.head      (head)
	);

	ps2_tx_fsm i_tx (
		.clk_sys      (clk_sys),
		.ps2_tick     (ps2_tick),
		.ps2_clk      (ps2_clk),
		.not_empty    (not_empty),
		.head         (head),
		.pop          (pop),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

endmodule

`default_nettype wire

// File: dv/user_io_tb.sv
/*
 * table-driven testbench for user_io_top with SPI transfer driver,
 * register and key event checks, ps/2 frame monitor and cycle timeout
 */

`timescale 1ns/10ps
`default_nettype none

module user_io_tb;

	localparam int PS2_DIV = 3;
	localparam int SPI_HALF = 4;
	localparam int FRAME_BITS = 11;
	// one ps/2 frame takes 12 full ps/2 periods from load to idle
	localparam int FRAME_CYCLES = 12 * 2 * (PS2_DIV + 1);
	localparam logic [31:0] SEED = 32'h214fc0e1;

	// one table row with the command in byte 0 and exp right-aligned
	typedef struct packed {
		logic [3:0]      len;
		logic [0:8][7:0] bytes;
		logic [63:0]     exp;
	} entry_t;

	logic clk_sys;
	logic SPI_SS_IO;
	logic SPI_CLK;
	logic SPI_MOSI;

	core_io_pkg::board_ctrl_t                               board_ctrl;
	core_io_pkg::joystick_t [core_io_pkg::NUM_JOYSTICKS-1:0] joysticks;
	core_io_pkg::status_t                                   status;
	core_io_pkg::core_mod_t                                 core_mod;
	core_io_pkg::key_event_t                                key;
	logic                                                   key_strobe;
	logic                                                   ps2_kbd_clk;
	logic                                                   ps2_kbd_data;

	entry_t     table_q [$];
	logic [7:0] exp_ps2 [$];

	// reference copies of the core-facing registers
	logic [6:0]  model_board = '0;
	logic [31:0] model_joy [5] = '{default: '0};
	logic [63:0] model_status = '0;
	logic [6:0]  model_core = '0;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int budget = 0;
	int key_count = 0;
	core_io_pkg::key_event_t key_last;
	logic [10:0] frame;
	int frame_bits = 0;

	user_io_top #(
		.PS2_DIV       (PS2_DIV),
		.PS2_FIFO_BITS (3)
	) i_dut (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.SPI_CLK      (SPI_CLK),
		.SPI_MOSI     (SPI_MOSI),
		.board_ctrl   (board_ctrl),
		.joysticks    (joysticks),
		.status       (status),
		.core_mod     (core_mod),
		.key          (key),
		.key_strobe   (key_strobe),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ends the run if the table takes far longer than its budget
	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("checks %0d, errors %0d", checks, errors);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// key strobes sampled mid-cycle
	always @(negedge clk_sys) begin
		if (key_strobe) begin
			key_count++;
			key_last = key;
		end
	end

	task automatic check_frame(input logic [10:0] f);
		logic [7:0] want;
		check_value("ps2 start bit", f[0], 1'b0);
		check_value("ps2 stop bit", f[10], 1'b1);
		// data plus parity hold an odd number of ones
		check_value("ps2 odd parity", ^f[9:1], 1'b1);
		checks++;
		assert (exp_ps2.size() != 0) else begin
			errors++;
			$display("a ps/2 frame with byte %0h arrived when none was expected", f[8:1]);
		end
		if (exp_ps2.size() != 0) begin
			want = exp_ps2.pop_front();
			check_value("ps2 data byte", f[8:1], want);
		end
	endtask

	// ps/2 monitor collects start bit first and stop bit last
	always @(negedge ps2_kbd_clk) begin
		frame[frame_bits] = ps2_kbd_data;
		frame_bits++;
		if (frame_bits == FRAME_BITS) begin
			check_frame(frame);
			frame_bits = 0;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// bits go out MSB first and the DUT samples on the rising SPI_CLK edge
	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			SPI_MOSI = b[i];
			SPI_CLK  = 1'b0;
			wait_cycles(SPI_HALF);
			SPI_CLK = 1'b1;
			wait_cycles(SPI_HALF);
		end
	endtask

	task automatic send_transfer(input entry_t e);
		SPI_SS_IO = 1'b0;
		wait_cycles(2);
		for (int k = 0; k < e.len; k++) begin
			send_byte(e.bytes[k]);
		end
		SPI_SS_IO = 1'b1;
		SPI_CLK   = 1'b0;
		wait_cycles(10);
	endtask

	// data is right-aligned and holds len bytes including the command
	task automatic add_entry(input int len, input logic [71:0] data, input logic [63:0] exp);
		entry_t e;
		e.len   = len;
		e.bytes = data << (8 * (9 - len));
		e.exp   = exp;
		table_q.push_back(e);
		budget += len * 8 * 2 * SPI_HALF + 10;
		// every keyboard byte goes out as a frame including the prefixes
		if (e.bytes[0] == 8'h05) begin
			for (int k = 1; k < len; k++) begin
				exp_ps2.push_back(e.bytes[k]);
				budget += FRAME_CYCLES;
			end
		end
	endtask

	// four random bytes LSB first plus a fifth one that must be ignored
	task automatic add_joystick(input logic [7:0] cmd);
		logic [31:0] r;
		logic [31:0] extra;
		r     = $urandom();
		extra = $urandom();
		add_entry(6, {cmd, r[7:0], r[15:8], r[23:16], r[31:24], extra[7:0]}, {32'd0, r});
	endtask

	task automatic check_outputs(input entry_t e);
		logic [7:0] cmd;
		cmd = e.bytes[0];
		if (cmd == 8'h01) begin
			model_board = e.exp[6:0];
		end else if (cmd >= 8'h60 && cmd <= 8'h64) begin
			model_joy[cmd - 8'h60] = e.exp[31:0];
		end else if (cmd == 8'h1e || cmd == 8'h15) begin
			model_status = e.exp;
		end else if (cmd == 8'h21) begin
			model_core = e.exp[6:0];
		end
		// exactly one key event per keyboard transfer and none for others
		check_value("key event count", key_count, (cmd == 8'h05) ? 1 : 0);
		if (cmd == 8'h05) begin
			check_value("key pressed", key_last.pressed, e.exp[9]);
			check_value("key extended", key_last.extended, e.exp[8]);
			check_value("key code", key_last.code, e.exp[7:0]);
		end
		// payload bits 6..0 with buttons in the low bits
		check_value("buttons", board_ctrl.buttons, model_board[1:0]);
		check_value("switches", board_ctrl.switches, model_board[3:2]);
		check_value("scandoubler_disable", board_ctrl.scandoubler_disable, model_board[4]);
		check_value("ypbpr", board_ctrl.ypbpr, model_board[5]);
		check_value("no_csync", board_ctrl.no_csync, model_board[6]);
		for (int j = 0; j < 5; j++) begin
			check_value($sformatf("joystick %0d", j), joysticks[j], model_joy[j]);
		end
		check_value("status", status, model_status);
		check_value("core_mod", core_mod, model_core);
	endtask

	initial begin
		int seed_ret;
		SPI_SS_IO = 1'b1;
		SPI_CLK   = 1'b0;
		SPI_MOSI  = 1'b0;
		seed_ret  = $urandom(SEED);

		add_entry(2, {8'h01, 8'hd5}, 64'h55);
		add_joystick(8'h60);
		add_joystick(8'h62);
		add_joystick(8'h64);
		add_entry(9, {8'h1e, 64'h1122334455667788}, 64'h8877665544332211);
		add_entry(2, {8'h15, 8'ha7}, 64'ha7);
		add_entry(2, {8'h21, 8'hff}, 64'h7f);
		// key events as {pressed, extended, code}
		add_entry(2, {8'h05, 8'h1c}, {54'd0, 2'b10, 8'h1c});
		add_entry(3, {8'h05, 8'hf0, 8'h1c}, {54'd0, 2'b00, 8'h1c});
		add_entry(3, {8'h05, 8'he0, 8'h75}, {54'd0, 2'b11, 8'h75});
		add_entry(4, {8'h05, 8'he0, 8'hf0, 8'h75}, {54'd0, 2'b01, 8'h75});
		cycle_limit = 2 * budget + 100;

		// chip select high acts as reset
		wait_cycles(5);
		check_value("idle ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		check_value("idle ps2_kbd_data", ps2_kbd_data, 1'b1);
		check_value("idle key_strobe", key_strobe, 1'b0);

		foreach (table_q[i]) begin
			key_count = 0;
			send_transfer(table_q[i]);
			check_outputs(table_q[i]);
		end

		// let the transmitter drain the FIFO
		while (exp_ps2.size() != 0) begin
			@(posedge clk_sys);
		end
		wait (ps2_kbd_clk == 1'b1);
		for (int c = 0; c < 3 * FRAME_CYCLES / 12; c++) begin
			wait_cycles(1);
			check_value("ps2_kbd_clk after last frame", ps2_kbd_clk, 1'b1);
		end
		check_value("partial frame bits", frame_bits, 0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rtl/spi_proto_pkg.sv
rtl/core_io_pkg.sv
rtl/spi_byte_rx.sv
rtl/io_cmd_decoder.sv
rtl/ps2_clk_div.sv
rtl/ps2_byte_fifo.sv
rtl/ps2_tx_fsm.sv
rtl/user_io_top.sv
dv/user_io_tb.sv

// File: Bender.yml
package:
  name: user_io

sources:
  # packages first
  - rtl/spi_proto_pkg.sv
  - rtl/core_io_pkg.sv
  # receive path and ps/2 transmitter
  - rtl/spi_byte_rx.sv
  - rtl/io_cmd_decoder.sv
  - rtl/ps2_clk_div.sv
  - rtl/ps2_byte_fifo.sv
  - rtl/ps2_tx_fsm.sv
  - rtl/user_io_top.sv
  - target: test
    files:
      - dv/user_io_tb.sv
